//--- design/macPkg.sv
package macPkg;

  //////////////////////////////
  // command codes
  //////////////////////////////

  // load replaces acc, add and sub fold in the old value
  typedef enum logic [1:0] {
    MAC_LOAD = 2'd0,
    MAC_ADD  = 2'd1,
    MAC_SUB  = 2'd2
  } macOp;

  //////////////////////////////
  // widths
  //////////////////////////////

  // 32 product bits plus 8 guard bits
  localparam int accWidth = 40;

  // signed operand width
  localparam int opWidth = 16;

  //////////////////////////////
  // rounding positions
  //////////////////////////////

  // bit that the product is rounded into
  localparam int roundBit = 16;

  // rounding constant is half an lsb of roundBit
  localparam int rndConstBit = roundBit - 1;

endpackage

//--- design/macBoothTree.sv
module macBoothTree #(
  parameter int guardBits = 8,
  localparam int accW = 2 * macPkg::opWidth + guardBits
) (
  input  logic [macPkg::opWidth-1:0] a,
  input  logic [macPkg::opWidth-1:0] b,
  input  macPkg::macOp               op,
  input  logic                       fracMode,
  input  logic                       rnd,
  input  logic [accW-1:0]            accIn,
  output logic [accW-1:0]            sum,
  output logic [accW-1:0]            carry
);

  // one extra digit covers the sign-extended top of b
  localparam int numDigits = macPkg::opWidth / 2 + 1;
  // partial products, negate bits, rounding constant, acc term
  localparam int numRows = numDigits + 3;

  logic [macPkg::opWidth+2:0] bExt;
  logic [accW-1:0]            aExt;
  logic [accW-1:0]            rows [numRows];
  logic [2*numDigits-1:0]     negPairs;
  logic [accW-1:0]            negRow;
  logic [accW-1:0]            rndRow;
  logic [accW-1:0]            accTerm;
  logic [accW-1:0]            sumChain;
  logic [accW-1:0]            carryChain;
  logic [accW-1:0]            majority;

  //////////////////////////////
  // radix-4 Booth recoding
  //////////////////////////////

  assign bExt = {b[macPkg::opWidth-1], b[macPkg::opWidth-1], b, 1'b0};
  assign aExt = {{(accW - macPkg::opWidth){a[macPkg::opWidth-1]}}, a};

  for (genvar k = 0; k < numDigits; k++) begin : genDigit
    logic [2:0]      digit;
    logic            one;
    logic            two;
    logic            neg;
    logic [accW-1:0] mag;

    assign digit = bExt[2*k+2:2*k];
    assign one   = digit[1] ^ digit[0];
    assign two   = (digit[2] & ~digit[1] & ~digit[0]) | (~digit[2] & digit[1] & digit[0]);
    assign neg   = digit[2];
    assign mag   = one ? aExt : (two ? (aExt << 1) : '0);

    // ones complement here, the +1 rides in negRow
    assign rows[k] = (neg ? ~mag : mag) << (2 * k + fracMode);
    assign negPairs[2*k+1:2*k] = {1'b0, neg};
  end

  // Q15 mode moves the whole product up one place
  assign negRow = accW'(negPairs) << fracMode;
  assign rndRow = accW'(rnd) << macPkg::rndConstBit;

  always_comb begin
    case (op)
      macPkg::MAC_ADD: accTerm = accIn;
      macPkg::MAC_SUB: accTerm = ~accIn;
      default:         accTerm = '0;
    endcase
  end

  assign rows[numDigits]   = negRow;
  assign rows[numDigits+1] = rndRow;
  assign rows[numDigits+2] = accTerm;

  //////////////////////////////
  // 3:2 compressor chain
  //////////////////////////////

  always_comb begin
    sumChain   = rows[0];
    carryChain = rows[1];
    majority   = '0;
    for (int i = 2; i < numRows; i++) begin
      majority   = (sumChain & carryChain) | (sumChain & rows[i]) | (carryChain & rows[i]);
      sumChain   = sumChain ^ carryChain ^ rows[i];
      carryChain = majority << 1;
    end
  end

  assign sum = sumChain;
  // bit 0 of the carry word is free, subtract uses it as carry-in
  assign carry = {carryChain[accW-1:1], op == macPkg::MAC_SUB};

endmodule

//--- design/macFinalAdder.sv
module macFinalAdder (
  input  logic [macPkg::accWidth-1:0] sum,
  input  logic [macPkg::accWidth-1:0] carry,
  input  logic                        rnd,
  input  logic                        biasRnd,
  output logic [macPkg::accWidth-1:0] result
);

  logic [macPkg::accWidth-1:0] halfSum;
  logic [38:0]                 p;
  logic [38:0]                 g;
  logic [18:0]                 p1;
  logic [18:0]                 g1;
  logic [8:0]                  p2;
  logic [8:0]                  g2;
  logic [2:1]                  p3;
  logic [2:0]                  g3;
  logic                        c12;
  logic                        c24;
  logic                        c36;
  logic [9:0]                  cFour;
  logic [19:0]                 cPair;
  logic [macPkg::accWidth-1:0] cBit;
  logic [macPkg::accWidth-1:0] raw;
  logic                        lowZero;
  logic                        tie;

  //////////////////////////////
  // group propagate/generate
  //////////////////////////////

  assign halfSum = sum ^ carry;
  assign p = sum[38:0] | carry[38:0];
  assign g = sum[38:0] & carry[38:0];

  for (genvar k = 0; k < 19; k++) begin : genPair
    assign g1[k] = g[2*k+1] | (g[2*k] & p[2*k+1]);
    assign p1[k] = p[2*k+1] & p[2*k];
  end

  for (genvar k = 0; k < 9; k++) begin : genFour
    assign g2[k] = g1[2*k+1] | (g1[2*k] & p1[2*k+1]);
    assign p2[k] = p1[2*k+1] & p1[2*k];
  end

  // twelve-bit groups, three fours each
  assign g3[0] = g2[2] | (g2[1] & p2[2]) | (g2[0] & p2[2] & p2[1]);
  assign g3[1] = g2[5] | (g2[4] & p2[5]) | (g2[3] & p2[5] & p2[4]);
  assign g3[2] = g2[8] | (g2[7] & p2[8]) | (g2[6] & p2[8] & p2[7]);
  assign p3[1] = p2[5] & p2[4] & p2[3];
  assign p3[2] = p2[8] & p2[7] & p2[6];

  // word-level carries at the twelve boundaries
  assign c12 = g3[0];
  assign c24 = g3[1] | (g3[0] & p3[1]);
  assign c36 = g3[2] | (g3[1] & p3[2]) | (g3[0] & p3[2] & p3[1]);

  //////////////////////////////
  // carry distribution
  //////////////////////////////

  assign cFour[0] = 1'b0;
  assign cFour[3] = c12;
  assign cFour[6] = c24;
  assign cFour[9] = c36;

  for (genvar k = 1; k < 9; k++) begin : genFourCarry
    if (k % 3 != 0) begin : genInner
      assign cFour[k] = g2[k-1] | (p2[k-1] & cFour[k-1]);
    end
  end

  for (genvar j = 0; j < 20; j++) begin : genPairCarry
    if (j % 2 == 0) begin : genEven
      assign cPair[j] = cFour[j/2];
    end else begin : genOdd
      assign cPair[j] = g1[j-1] | (p1[j-1] & cFour[j/2]);
    end
  end

  for (genvar i = 0; i < macPkg::accWidth; i++) begin : genBitCarry
    if (i % 2 == 0) begin : genEven
      assign cBit[i] = cPair[i/2];
    end else begin : genOdd
      assign cBit[i] = g[i-1] | (p[i-1] & cPair[i/2]);
    end
  end

  // carry out of bit 39 drops, acc wraps modulo 2^40
  assign raw = halfSum ^ cBit;

  //////////////////////////////
  // convergent tie fix
  //////////////////////////////

  assign lowZero = ~|raw[macPkg::roundBit-1:0];
  assign tie     = rnd & ~biasRnd & lowZero;

  assign result = {raw[macPkg::accWidth-1:macPkg::roundBit+1],
                   raw[macPkg::roundBit] & ~tie,
                   raw[macPkg::roundBit-1:0]};

endmodule

//--- design/macAccumulator.sv
module macAccumulator #(
  parameter int guardBits = 8,
  localparam int accW = 2 * macPkg::opWidth + guardBits
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  logic            update,
  input  logic [accW-1:0] sumIn,
  input  logic [accW-1:0] carryIn,
  input  logic            rndIn,
  input  logic            biasRndIn,
  input  logic [accW-1:0] result,
  output logic [accW-1:0] sum,
  output logic [accW-1:0] carry,
  output logic            rnd,
  output logic            biasRnd,
  output logic [accW-1:0] acc
);

  //////////////////////////////
  // tree to final adder
  //////////////////////////////

  // redundant pair and rounding mode captured together
  always_ff @(posedge clk) begin
    if (start) begin
      sum     <= sumIn;
      carry   <= carryIn;
      rnd     <= rndIn;
      biasRnd <= biasRndIn;
    end
  end

  //////////////////////////////
  // accumulator
  //////////////////////////////

  // result is combinational off the registered pair
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (update) begin
      acc <= result;
    end
  end

endmodule

//--- design/macCore.sv
module macCore #(
  parameter int guardBits = 8,
  localparam int accW = 2 * macPkg::opWidth + guardBits
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req,
  input  macPkg::macOp               op,
  input  logic [macPkg::opWidth-1:0] a,
  input  logic [macPkg::opWidth-1:0] b,
  input  logic                       fracMode,
  input  logic                       rnd,
  input  logic                       biasRnd,
  output logic                       ack,
  output logic [accW-1:0]            acc
);

  localparam logic [2:0] stateIdle    = 3'd0;
  localparam logic [2:0] stateTree    = 3'd1;
  localparam logic [2:0] stateWrite   = 3'd2;
  localparam logic [2:0] stateAckHigh = 3'd3;
  localparam logic [2:0] stateWaitLow = 3'd4;

  logic [2:0]      state;
  logic            start;
  logic            update;
  logic [accW-1:0] treeSum;
  logic [accW-1:0] treeCarry;
  logic [accW-1:0] stageSum;
  logic [accW-1:0] stageCarry;
  logic            stageRnd;
  logic            stageBiasRnd;
  logic [accW-1:0] result;

  //////////////////////////////
  // four-phase command FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stateIdle;
    end else begin
      case (state)
        stateIdle:    if (req) state <= stateTree;
        stateTree:    state <= stateWrite;
        stateWrite:   state <= stateAckHigh;
        stateAckHigh: if (!req) state <= stateWaitLow;
        stateWaitLow: state <= stateIdle;
        default:      state <= stateIdle;
      endcase
    end
  end

  // operands are stable while req is high
  assign start  = state == stateTree;
  assign update = state == stateWrite;
  // ack holds one cycle past req low
  assign ack    = (state == stateAckHigh) || (state == stateWaitLow);

  //////////////////////////////
  // datapath
  //////////////////////////////

  macBoothTree #(
    .guardBits(guardBits)
  ) i_macBoothTree (
    .a       (a),
    .b       (b),
    .op      (op),
    .fracMode(fracMode),
    .rnd     (rnd),
    .accIn   (acc),
    .sum     (treeSum),
    .carry   (treeCarry)
  );

  macAccumulator #(
    .guardBits(guardBits)
  ) i_macAccumulator (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .update   (update),
    .sumIn    (treeSum),
    .carryIn  (treeCarry),
    .rndIn    (rnd),
    .biasRndIn(biasRnd),
    .result   (result),
    .sum      (stageSum),
    .carry    (stageCarry),
    .rnd      (stageRnd),
    .biasRnd  (stageBiasRnd),
    .acc      (acc)
  );

  macFinalAdder i_macFinalAdder (
    .sum    (stageSum),
    .carry  (stageCarry),
    .rnd    (stageRnd),
    .biasRnd(stageBiasRnd),
    .result (result)
  );

endmodule

//--- include/macRefModel.svh
`ifndef MAC_REF_MODEL_SVH
`define MAC_REF_MODEL_SVH

// signed product, doubled in Q15 mode
function automatic logic [macPkg::accWidth-1:0] scaledProduct(
  input logic signed [macPkg::opWidth-1:0] a,
  input logic signed [macPkg::opWidth-1:0] b,
  input logic                              fracMode
);
  logic signed [macPkg::accWidth-1:0] prod;
  prod = a * b;
  if (fracMode) begin
    prod = prod <<< 1;
  end
  return prod;
endfunction

// half an lsb of the rounding bit
function automatic logic [macPkg::accWidth-1:0] addRounding(
  input logic [macPkg::accWidth-1:0] value,
  input logic                        rnd
);
  logic [macPkg::accWidth-1:0] bias;
  bias = '0;
  bias[macPkg::rndConstBit] = rnd;
  return value + bias;
endfunction

// subtract leaves the rounded product minus the old acc
function automatic logic [macPkg::accWidth-1:0] nextAcc(
  input logic [macPkg::accWidth-1:0] accOld,
  input macPkg::macOp                op,
  input logic [macPkg::accWidth-1:0] term,
  input logic                        rnd,
  input logic                        biasRnd
);
  logic [macPkg::accWidth-1:0] next;
  case (op)
    macPkg::MAC_ADD: next = accOld + term;
    macPkg::MAC_SUB: next = term - accOld;
    default:         next = term;
  endcase
  if (rnd && !biasRnd && next[macPkg::roundBit-1:0] == '0) begin
    next[macPkg::roundBit] = 1'b0;
  end
  return next;
endfunction

`endif

//--- bench/macCoreTb.sv
module macCoreTb;

  localparam int waitLimit = 20;

  logic                              clk;
  logic                              reset;
  logic                              req;
  macPkg::macOp                      op;
  logic [macPkg::opWidth-1:0]        a;
  logic [macPkg::opWidth-1:0]        b;
  logic                              fracMode;
  logic                              rnd;
  logic                              biasRnd;
  logic                              ack;
  logic [macPkg::accWidth-1:0]       acc;
  int                                seed;
  logic [macPkg::accWidth-1:0]       accModel;
  logic [macPkg::accWidth-1:0]       prevAcc;
  macPkg::macOp                      cmd;

  `include "macRefModel.svh"

  macCore #(
    .guardBits(8)
  ) i_macCore (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .op      (op),
    .a       (a),
    .b       (b),
    .fracMode(fracMode),
    .rnd     (rnd),
    .biasRnd (biasRnd),
    .ack     (ack),
    .acc     (acc)
  );

  always #50 clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [macPkg::accWidth-1:0] expected,
                            input logic [macPkg::accWidth-1:0] actual);
    assert (actual == expected) else
      abortRun($sformatf("CHECK FAILED %s expected %h got %h", name, expected, actual));
  endtask

  //////////////////////////////
  // one four-phase command
  //////////////////////////////

  // entered and left 5 units after a rising edge
  task automatic runCommand(input macPkg::macOp cmdOp, input logic [15:0] opA,
                            input logic [15:0] opB, input logic frac, input logic r,
                            input logic bias);
    logic [macPkg::accWidth-1:0] expected;
    int                          cycles;
    expected = nextAcc(accModel, cmdOp, addRounding(scaledProduct(opA, opB, frac), r),
                       r, bias);
    op       = cmdOp;
    a        = opA;
    b        = opB;
    fracMode = frac;
    rnd      = r;
    biasRnd  = bias;
    req      = 1'b1;
    // edge that samples req high
    @(posedge clk);
    #5;
    cycles = 0;
    while (!ack) begin
      if (cycles == waitLimit) abortRun("ack never rose after the request");
      @(posedge clk);
      #5;
      cycles++;
    end
    checkValue("ackRiseCycles", 40'd2, 40'(cycles));
    checkValue("acc", expected, acc);
    accModel = expected;
    req      = 1'b0;
    @(posedge clk);
    #5;
    cycles = 0;
    while (ack) begin
      if (cycles == waitLimit) abortRun("ack never fell after req was dropped");
      @(posedge clk);
      #5;
      cycles++;
    end
    checkValue("ackFallCycles", 40'd1, 40'(cycles));
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    seed     = 13;
    clk      = 1'b0;
    reset    = 1'b1;
    req      = 1'b0;
    op       = macPkg::MAC_LOAD;
    a        = '0;
    b        = '0;
    fracMode = 1'b0;
    rnd      = 1'b0;
    biasRnd  = 1'b0;
    accModel = '0;
    repeat (16) @(posedge clk);
    #5;
    reset = 1'b0;
    checkValue("ack", 40'd0, 40'(ack));
    checkValue("acc", 40'd0, acc);

    // plain loads, largest product first
    runCommand(macPkg::MAC_LOAD, 16'h8000, 16'h8000, 1'b0, 1'b0, 1'b0);
    repeat (12) runCommand(macPkg::MAC_LOAD, 16'($random(seed)), 16'($random(seed)),
                           1'b0, 1'b0, 1'b0);

    // running sum, wraps through all 40 bits
    for (int i = 0; i < 24; i++) begin
      if ($random(seed) & 1) cmd = macPkg::MAC_ADD;
      else cmd = macPkg::MAC_SUB;
      runCommand(cmd, 16'($random(seed)), 16'($random(seed)), 1'b0, 1'b0, 1'b0);
    end

    // Q15 doubling and biased rounding
    runCommand(macPkg::MAC_LOAD, 16'h1234, 16'hc321, 1'b0, 1'b0, 1'b0);
    prevAcc = accModel;
    runCommand(macPkg::MAC_LOAD, 16'h1234, 16'hc321, 1'b1, 1'b0, 1'b0);
    checkValue("acc", prevAcc << 1, acc);
    runCommand(macPkg::MAC_LOAD, 16'h1234, 16'hc321, 1'b1, 1'b1, 1'b1);
    checkValue("acc", (prevAcc << 1) + 40'h8000, acc);

    // exact ties land on an even bit 16
    runCommand(macPkg::MAC_LOAD, 16'h0003, 16'h8000, 1'b0, 1'b1, 1'b0);
    checkValue("acc", 40'hff_fffe_0000, acc);
    runCommand(macPkg::MAC_LOAD, 16'h0002, 16'h4000, 1'b0, 1'b1, 1'b0);
    checkValue("acc", 40'h0, acc);

    // mixed modes, non-ties round like the biased case
    for (int i = 0; i < 16; i++) begin
      if ($random(seed) & 1) cmd = macPkg::MAC_ADD;
      else cmd = macPkg::MAC_SUB;
      runCommand(cmd, 16'($random(seed)), 16'($random(seed)), 1'($random(seed)), 1'b1,
                 1'($random(seed)));
    end

    $display("Test OK");
    $finish;
  end

endmodule

//--- all.f
+incdir+include
design/macPkg.sv
design/macBoothTree.sv
design/macFinalAdder.sv
design/macAccumulator.sv
design/macCore.sv
bench/macCoreTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run, exit status carries pass or fail
cd "$(dirname "$0")" &&
  verilator --binary --timing -f all.f --top-module macCoreTb -o macCoreSim &&
  ./obj_dir/macCoreSim ||
  exit 1
